//--- all.f
rtl/rob_cfg_pkg.sv
rtl/rob_types_pkg.sv
rtl/rob_write_if.sv
rtl/rob_multiport_ram.sv
rtl/rob_pointer_ctrl.sv
rtl/rob_complete_tracker.sv
rtl/rob_top.sv
tests/rob_sva.sv
tests/tb_rob.sv

//--- tests/tb_rob.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rob;

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    localparam int MAX_WAIT = 50;

    logic                  clk;
    logic                  reset_i;
    logic                  flush_i;
    logic [1:0]            dispatch_valid_i;
    logic [PC_WIDTH-1:0]   dispatch_pc_i [2];
    logic [AREG_WIDTH-1:0] dispatch_areg_i [2];
    logic [1:0]            dispatch_w_reg_i;
    rob_id_t               src_id_i [4];
    rob_id_t               dispatch_rob_id_o [2];
    logic                  dispatch_ready_o;
    rob_word_u             src_word_o [4];
    logic [3:0]            src_complete_o;
    logic [1:0]            cdb_valid_i;
    rob_id_t               cdb_id_i [2];
    rob_word_u             cdb_word_i [2];
    logic [1:0]            cdb_exc_i;
    logic [1:0]            commit_req_i;
    logic [1:0]            commit_valid_o;
    logic [PC_WIDTH-1:0]   commit_pc_o [2];
    logic [AREG_WIDTH-1:0] commit_areg_o [2];
    logic [1:0]            commit_w_reg_o;
    rob_word_u             commit_word_o [2];
    logic [1:0]            commit_exc_o;

    // reference model with held entries oldest first
    rob_id_t               exp_q [$];
    rob_id_t               model_head;
    logic [PC_WIDTH-1:0]   model_pc [ROB_DEPTH];
    logic [AREG_WIDTH-1:0] model_areg [ROB_DEPTH];
    logic                  model_w_reg [ROB_DEPTH];
    rob_word_u             model_word [ROB_DEPTH];
    logic                  model_exc [ROB_DEPTH];
    // completion survives commit and flush as in the flip tables
    logic                  model_done [ROB_DEPTH];

    logic [31:0] lcg_state;
    int          err_count;
    int          timeout_count;

    rob_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rob_word_u rand_word();
        rob_word_u w;
        w.result = next_rand();
        return w;
    endfunction

    // inputs change 10 ns after the edge
    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic drive_idle();
        flush_i          = 1'b0;
        dispatch_valid_i = 2'b00;
        dispatch_w_reg_i = 2'b00;
        cdb_valid_i      = 2'b00;
        cdb_exc_i        = 2'b00;
        commit_req_i     = 2'b00;
        for (int k = 0; k < 2; k++) begin
            dispatch_pc_i[k]   = '0;
            dispatch_areg_i[k] = '0;
            cdb_id_i[k]        = '0;
            cdb_word_i[k]      = '0;
        end
        for (int i = 0; i < 4; i++) begin
            src_id_i[i] = '0;
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 err_count, timeout_count, i_dut.i_pointer_ctrl.i_rob_sva.fail_count);
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout: %s did not rise within %0d cycles", what, MAX_WAIT);
        print_counts();
        $display("*** FAILED ***");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////

    task automatic check_id(input string name, input rob_id_t got, input rob_id_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input rob_word_u got, input rob_word_u exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_exc(input string name, input rob_exc_word_t got,
                             input rob_exc_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got code %h badva %h expected code %h badva %h",
                     $time, name, got.exc_code, got.badva_lo, exp.exc_code, exp.badva_lo);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_pc(input string name, input logic [PC_WIDTH-1:0] got,
                            input logic [PC_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_areg(input string name, input logic [AREG_WIDTH-1:0] got,
                              input logic [AREG_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
            err_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////
    // model checks and bounded waits
    //////////////////////////////////////////////////////////////

    task automatic check_state();
        logic    exp_cv [2];
        rob_id_t id;
        exp_cv[0] = 1'b0;
        exp_cv[1] = 1'b0;
        if (exp_q.size() >= 1) begin
            exp_cv[0] = model_done[exp_q[0]];
        end
        if (exp_q.size() >= 2) begin
            exp_cv[1] = exp_cv[0] & model_done[exp_q[1]];
        end
        #1;
        check_bit("dispatch_ready_o", dispatch_ready_o, exp_q.size() <= ROB_DEPTH - 2);
        for (int k = 0; k < 2; k++) begin
            check_bit($sformatf("commit_valid_o[%0d]", k), commit_valid_o[k], exp_cv[k]);
            if (exp_cv[k]) begin
                id = exp_q[k];
                check_pc($sformatf("commit_pc_o[%0d]", k), commit_pc_o[k], model_pc[id]);
                check_areg($sformatf("commit_areg_o[%0d]", k), commit_areg_o[k],
                           model_areg[id]);
                check_bit($sformatf("commit_w_reg_o[%0d]", k), commit_w_reg_o[k],
                          model_w_reg[id]);
                check_word($sformatf("commit_word_o[%0d]", k), commit_word_o[k],
                           model_word[id]);
                check_bit($sformatf("commit_exc_o[%0d]", k), commit_exc_o[k], model_exc[id]);
            end
        end
    endtask

    task automatic check_sources(input rob_id_t id0, input rob_id_t id1,
                                 input rob_id_t id2, input rob_id_t id3);
        rob_id_t ids [4];
        ids = '{id0, id1, id2, id3};
        for (int i = 0; i < 4; i++) begin
            src_id_i[i] = ids[i];
        end
        #1;
        for (int i = 0; i < 4; i++) begin
            check_bit($sformatf("src_complete_o[%0d]", i), src_complete_o[i],
                      model_done[ids[i]]);
            if (model_done[ids[i]]) begin
                check_word($sformatf("src_word_o[%0d]", i), src_word_o[i],
                           model_word[ids[i]]);
            end
        end
    endtask

    task automatic wait_dispatch_ready();
        int cycles;
        cycles = 0;
        #1;
        while (dispatch_ready_o !== 1'b1 && cycles < MAX_WAIT) begin
            tick();
            cycles++;
        end
        if (cycles >= MAX_WAIT) begin
            report_timeout("dispatch_ready_o");
        end
    endtask

    task automatic wait_commit(input int n);
        int cycles;
        cycles = 0;
        #1;
        while (commit_valid_o[n-1] !== 1'b1 && cycles < MAX_WAIT) begin
            tick();
            cycles++;
        end
        if (cycles >= MAX_WAIT) begin
            report_timeout($sformatf("commit_valid_o[%0d]", n - 1));
        end
    endtask

    //////////////////////////////////////////////////////////////
    // bus operations
    //////////////////////////////////////////////////////////////

    task automatic dispatch_pair(input int n);
        logic [31:0] rnd;
        rob_id_t     id;
        wait_dispatch_ready();
        for (int k = 0; k < n; k++) begin
            id  = model_head + rob_id_t'(k);
            rnd = next_rand();
            dispatch_pc_i[k]    = next_rand();
            dispatch_areg_i[k]  = rnd[AREG_WIDTH-1:0];
            dispatch_w_reg_i[k] = rnd[31];
            dispatch_valid_i[k] = 1'b1;
            model_pc[id]    = dispatch_pc_i[k];
            model_areg[id]  = rnd[AREG_WIDTH-1:0];
            model_w_reg[id] = rnd[31];
            model_done[id]  = 1'b0;
            exp_q.push_back(id);
        end
        #1;
        for (int k = 0; k < n; k++) begin
            check_id($sformatf("dispatch_rob_id_o[%0d]", k), dispatch_rob_id_o[k],
                     model_head + rob_id_t'(k));
        end
        tick();
        dispatch_valid_i = 2'b00;
        model_head = model_head + rob_id_t'(n);
    endtask

    task automatic writeback(input logic [1:0] lanes, input rob_id_t id0, input rob_id_t id1,
                             input rob_word_u w0, input rob_word_u w1, input logic [1:0] exc);
        rob_id_t   ids [2];
        rob_word_u words [2];
        ids   = '{id0, id1};
        words = '{w0, w1};
        for (int k = 0; k < 2; k++) begin
            cdb_id_i[k]   = ids[k];
            cdb_word_i[k] = words[k];
            if (lanes[k]) begin
                model_word[ids[k]] = words[k];
                model_exc[ids[k]]  = exc[k];
                model_done[ids[k]] = 1'b1;
            end
        end
        cdb_valid_i = lanes;
        cdb_exc_i   = exc;
        tick();
        cdb_valid_i = 2'b00;
        cdb_exc_i   = 2'b00;
    endtask

    task automatic commit(input int n);
        wait_commit(n);
        check_state();
        commit_req_i = (n == 2) ? 2'b11 : 2'b01;
        tick();
        commit_req_i = 2'b00;
        for (int k = 0; k < n; k++) begin
            void'(exp_q.pop_front());
        end
    endtask

    // complete and retire whatever is still held one entry at a time
    task automatic drain();
        while (exp_q.size() > 0) begin
            if (model_done[exp_q[0]] !== 1'b1) begin
                writeback(2'b01, exp_q[0], exp_q[0], rand_word(), rand_word(), 2'b00);
            end
            commit(1);
        end
    endtask

    task automatic flush_rob();
        flush_i = 1'b1;
        tick();
        flush_i = 1'b0;
        exp_q.delete();
        model_head = '0;
    endtask

    //////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        check_state();
        dispatch_pair(2);
        check_sources(exp_q[0], exp_q[1], exp_q[0], exp_q[1]);
        drain();
    endtask

    // eight pairs move the head past the wrap and the single leaves it odd
    task automatic test_dispatch_ids();
        for (int i = 0; i < 8; i++) begin
            dispatch_pair(2);
            check_sources(exp_q[0], exp_q[1], exp_q[1], exp_q[0]);
            drain();
        end
        dispatch_pair(1);
        check_sources(exp_q[0], exp_q[0], exp_q[0], exp_q[0]);
        drain();
    endtask

    task automatic test_writeback_commit();
        rob_id_t a, b, c, d;
        dispatch_pair(2);
        dispatch_pair(2);
        a = exp_q[0];
        b = exp_q[1];
        c = exp_q[2];
        d = exp_q[3];
        // second oldest alone keeps commit closed
        writeback(2'b01, b, b, rand_word(), rand_word(), 2'b00);
        check_state();
        check_sources(b, a, c, d);
        writeback(2'b11, a, c, rand_word(), rand_word(), 2'b00);
        check_sources(a, b, c, d);
        commit(2);
        check_state();
        writeback(2'b10, d, d, rand_word(), rand_word(), 2'b00);
        commit(2);
        check_state();
    endtask

    task automatic test_exception_word();
        logic [31:0]   rnd;
        rob_exc_word_t exp_rec;
        rob_word_u     w;
        dispatch_pair(2);
        rnd = next_rand();
        exp_rec.exc_code = rnd[EXC_CODE_WIDTH-1:0];
        exp_rec.badva_lo = rnd[31:EXC_CODE_WIDTH];
        w.exc = exp_rec;
        // lane 0 carries the exception for the younger entry
        writeback(2'b11, exp_q[1], exp_q[0], w, rand_word(), 2'b01);
        wait_commit(2);
        check_exc("commit_word_o[1].exc", commit_word_o[1].exc, exp_rec);
        check_bit("commit_exc_o[1]", commit_exc_o[1], 1'b1);
        commit(2);
        check_state();
    endtask

    task automatic test_full_backpressure();
        for (int i = 0; i < 7; i++) begin
            dispatch_pair(2);
        end
        check_state();
        dispatch_pair(1);
        check_state();
        for (int i = 0; i < 3; i++) begin
            tick();
            check_state();
        end
        writeback(2'b11, exp_q[0], exp_q[1], rand_word(), rand_word(), 2'b00);
        commit(1);
        check_state();
        dispatch_pair(2);
        check_state();
        drain();
        check_state();
    endtask

    task automatic test_flush();
        flush_rob();
        check_state();
        dispatch_pair(2);
        dispatch_pair(2);
        writeback(2'b11, exp_q[0], exp_q[1], rand_word(), rand_word(), 2'b00);
        check_state();
        flush_rob();
        check_state();
        // entries 0 and 1 still carry completed flip bits
        check_sources(rob_id_t'(0), rob_id_t'(1), rob_id_t'(2), rob_id_t'(3));
        dispatch_pair(2);
        check_sources(rob_id_t'(0), rob_id_t'(1), rob_id_t'(2), rob_id_t'(3));
        drain();
        check_state();
    endtask

    //////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////

    initial begin
        err_count     = 0;
        timeout_count = 0;
        lcg_state     = 32'd60418;
        model_head    = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            model_done[i] = 1'b0;
        end
        reset_i = 1'b1;
        drive_idle();
        repeat (5) @(posedge clk);
        #10;
        reset_i = 1'b0;

        test_reset_state();
        test_dispatch_ids();
        test_writeback_commit();
        test_exception_word();
        test_full_backpressure();
        test_flush();

        print_counts();
        if (err_count == 0 && timeout_count == 0 &&
            i_dut.i_pointer_ctrl.i_rob_sva.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/rob_sva.sv
`timescale 1ns/100ps
`default_nettype none

module rob_sva (
    input wire logic                             clk,
    input wire logic                             reset_i,
    input wire logic [1:0]                       dispatch_valid_i,
    input wire logic [1:0]                       commit_req_i,
    input wire logic [rob_cfg_pkg::ROB_WIDTH:0]  count_q
);

    import rob_cfg_pkg::*;

    // running total of failed assertions
    int fail_count = 0;

    // upper dispatch lane only together with the lower one
    dispatch_lane_order: assert property (
        @(posedge clk) disable iff (reset_i)
        dispatch_valid_i[1] |-> dispatch_valid_i[0]
    ) else begin
        $error("dispatch lane 1 raised without lane 0");
        fail_count++;
    end

    // commit stays in order
    commit_lane_order: assert property (
        @(posedge clk) disable iff (reset_i)
        commit_req_i[1] |-> commit_req_i[0]
    ) else begin
        $error("commit request 1 raised without request 0");
        fail_count++;
    end

    count_bound: assert property (
        @(posedge clk) disable iff (reset_i)
        count_q <= (ROB_WIDTH+1)'(ROB_DEPTH)
    ) else begin
        $error("occupancy count above buffer depth");
        fail_count++;
    end

endmodule

bind rob_pointer_ctrl rob_sva i_rob_sva (
    .clk              (clk),
    .reset_i          (reset_i),
    .dispatch_valid_i (dispatch_valid_i),
    .commit_req_i     (commit_req_i),
    .count_q          (count_q)
);

`default_nettype wire

//--- rtl/rob_top.sv
`timescale 1ns/100ps
`default_nettype none

module rob_top (
    input  wire logic                                clk,
    input  wire logic                                reset_i,
    input  wire logic                                flush_i,
    // dispatch
    input  wire logic [1:0]                          dispatch_valid_i,
    input  wire logic [rob_cfg_pkg::PC_WIDTH-1:0]    dispatch_pc_i [2],
    input  wire logic [rob_cfg_pkg::AREG_WIDTH-1:0]  dispatch_areg_i [2],
    input  wire logic [1:0]                          dispatch_w_reg_i,
    input  rob_cfg_pkg::rob_id_t                     src_id_i [4],
    output rob_cfg_pkg::rob_id_t                     dispatch_rob_id_o [2],
    output logic                                     dispatch_ready_o,
    output rob_types_pkg::rob_word_u                 src_word_o [4],
    output logic [3:0]                               src_complete_o,
    // writeback
    input  wire logic [1:0]                          cdb_valid_i,
    input  rob_cfg_pkg::rob_id_t                     cdb_id_i [2],
    input  rob_types_pkg::rob_word_u                 cdb_word_i [2],
    input  wire logic [1:0]                          cdb_exc_i,
    // commit
    input  wire logic [1:0]                          commit_req_i,
    output logic [1:0]                               commit_valid_o,
    output logic [rob_cfg_pkg::PC_WIDTH-1:0]         commit_pc_o [2],
    output logic [rob_cfg_pkg::AREG_WIDTH-1:0]       commit_areg_o [2],
    output logic [1:0]                               commit_w_reg_o,
    output rob_types_pkg::rob_word_u                 commit_word_o [2],
    output logic [1:0]                               commit_exc_o
);

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    rob_inst_entry_t disp_entry [2];
    rob_data_entry_t cdb_entry  [2];
    rob_inst_entry_t inst_rd    [2];
    rob_data_entry_t data_rd    [6];
    rob_id_t         data_raddr [6];
    rob_id_t         tail_id    [2];
    logic [1:0]      tail_complete;
    logic            held_one;
    logic            held_two;

    rob_write_if #(.WIDTH($bits(rob_inst_entry_t))) inst_wr ();
    rob_write_if #(.WIDTH($bits(rob_data_entry_t))) data_wr ();

    //////////////////////////////////////////////////////////////
    // control and completion
    //////////////////////////////////////////////////////////////

    rob_pointer_ctrl i_pointer_ctrl (
        .clk               (clk),
        .reset_i           (reset_i),
        .flush_i           (flush_i),
        .dispatch_valid_i  (dispatch_valid_i),
        .commit_req_i      (commit_req_i),
        .inst_addr_wr      (inst_wr),
        .dispatch_rob_id_o (dispatch_rob_id_o),
        .dispatch_ready_o  (dispatch_ready_o),
        .tail_id_o         (tail_id),
        .held_one_o        (held_one),
        .held_two_o        (held_two)
    );

    // the instruction lanes double as dispatch flip requests
    rob_complete_tracker i_complete_tracker (
        .clk               (clk),
        .reset_i           (reset_i),
        .dispatch_flip_req (inst_wr),
        .cdb_valid_i       (cdb_valid_i),
        .cdb_id_i          (cdb_id_i),
        .src_id_i          (src_id_i),
        .tail_id_i         (tail_id),
        .src_complete_o    (src_complete_o),
        .tail_complete_o   (tail_complete)
    );

    //////////////////////////////////////////////////////////////
    // write data for both tables
    //////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            disp_entry[k].pc    = dispatch_pc_i[k];
            disp_entry[k].areg  = dispatch_areg_i[k];
            disp_entry[k].w_reg = dispatch_w_reg_i[k];
            cdb_entry[k].word   = cdb_word_i[k];
            cdb_entry[k].exc    = cdb_exc_i[k];
        end
    end

    assign inst_wr.wdata = {disp_entry[1], disp_entry[0]};

    assign data_wr.we    = cdb_valid_i;
    assign data_wr.waddr = {cdb_id_i[1], cdb_id_i[0]};
    assign data_wr.wdata = {cdb_entry[1], cdb_entry[0]};

    //////////////////////////////////////////////////////////////
    // tables
    //////////////////////////////////////////////////////////////

    rob_multiport_ram #(
        .DATA_WIDTH     ($bits(rob_inst_entry_t)),
        .R_PORTS        (2),
        .CLEAR_ON_RESET (1'b0)
    ) i_inst_table (
        .clk     (clk),
        .reset_i (reset_i),
        .wr      (inst_wr),
        .raddr_i (tail_id),
        .rdata_o (inst_rd)
    );

    // four source reads, then the two oldest
    assign data_raddr = '{src_id_i[0], src_id_i[1], src_id_i[2], src_id_i[3],
                          tail_id[0], tail_id[1]};

    rob_multiport_ram #(
        .DATA_WIDTH     ($bits(rob_data_entry_t)),
        .R_PORTS        (6),
        .CLEAR_ON_RESET (1'b0)
    ) i_data_table (
        .clk     (clk),
        .reset_i (reset_i),
        .wr      (data_wr),
        .raddr_i (data_raddr),
        .rdata_o (data_rd)
    );

    //////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////

    // in order only: the second slot needs the first
    assign commit_valid_o[0] = held_one & tail_complete[0];
    assign commit_valid_o[1] = held_two & tail_complete[1] & commit_valid_o[0];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            src_word_o[i] = data_rd[i].word;
        end
        for (int k = 0; k < 2; k++) begin
            commit_pc_o[k]    = inst_rd[k].pc;
            commit_areg_o[k]  = inst_rd[k].areg;
            commit_w_reg_o[k] = inst_rd[k].w_reg;
            commit_word_o[k]  = data_rd[4+k].word;
            commit_exc_o[k]   = data_rd[4+k].exc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rob_complete_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module rob_complete_tracker (
    input  wire logic            clk,
    input  wire logic            reset_i,
    rob_write_if.dst             dispatch_flip_req,
    input  wire logic [1:0]      cdb_valid_i,
    input  rob_cfg_pkg::rob_id_t cdb_id_i [2],
    input  rob_cfg_pkg::rob_id_t src_id_i [4],
    input  rob_cfg_pkg::rob_id_t tail_id_i [2],
    output logic [3:0]           src_complete_o,
    output logic [1:0]           tail_complete_o
);

    import rob_cfg_pkg::*;

    // read ports 0-3 source, 4-5 tail, 6-7 the other table's write address
    rob_id_t    disp_raddr [8];
    rob_id_t    cdb_raddr  [8];
    logic [0:0] disp_rd    [8];
    logic [0:0] cdb_rd     [8];

    rob_write_if #(.WIDTH(1)) dispatch_flip ();
    rob_write_if #(.WIDTH(1)) cdb_flip ();

    assign disp_raddr = '{src_id_i[0], src_id_i[1], src_id_i[2], src_id_i[3],
                          tail_id_i[0], tail_id_i[1], cdb_id_i[0], cdb_id_i[1]};
    assign cdb_raddr  = '{src_id_i[0], src_id_i[1], src_id_i[2], src_id_i[3],
                          tail_id_i[0], tail_id_i[1],
                          dispatch_flip_req.waddr[0], dispatch_flip_req.waddr[1]};

    //////////////////////////////////////////////////////////////
    // flip writes
    //////////////////////////////////////////////////////////////

    // dispatch copies the cdb bit, entry reads as pending
    assign dispatch_flip.we    = dispatch_flip_req.we;
    assign dispatch_flip.waddr = dispatch_flip_req.waddr;
    assign dispatch_flip.wdata = {cdb_rd[7], cdb_rd[6]};

    // cdb stores the inverted dispatch bit, entry reads as complete
    assign cdb_flip.we    = cdb_valid_i;
    assign cdb_flip.waddr = {cdb_id_i[1], cdb_id_i[0]};
    assign cdb_flip.wdata = {~disp_rd[7], ~disp_rd[6]};

    rob_multiport_ram #(
        .DATA_WIDTH     (1),
        .R_PORTS        (8),
        .CLEAR_ON_RESET (1'b1)
    ) i_dispatch_table (
        .clk     (clk),
        .reset_i (reset_i),
        .wr      (dispatch_flip),
        .raddr_i (disp_raddr),
        .rdata_o (disp_rd)
    );

    rob_multiport_ram #(
        .DATA_WIDTH     (1),
        .R_PORTS        (8),
        .CLEAR_ON_RESET (1'b1)
    ) i_cdb_table (
        .clk     (clk),
        .reset_i (reset_i),
        .wr      (cdb_flip),
        .raddr_i (cdb_raddr),
        .rdata_o (cdb_rd)
    );

    //////////////////////////////////////////////////////////////
    // completion = bits differ
    //////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            src_complete_o[i] = disp_rd[i][0] ^ cdb_rd[i][0];
        end
        for (int k = 0; k < 2; k++) begin
            tail_complete_o[k] = disp_rd[4+k][0] ^ cdb_rd[4+k][0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/rob_pointer_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rob_pointer_ctrl (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           flush_i,
    input  wire logic [1:0]     dispatch_valid_i,
    input  wire logic [1:0]     commit_req_i,
    rob_write_if.src            inst_addr_wr,
    output rob_cfg_pkg::rob_id_t dispatch_rob_id_o [2],
    output logic                dispatch_ready_o,
    output rob_cfg_pkg::rob_id_t tail_id_o [2],
    output logic                held_one_o,
    output logic                held_two_o
);

    import rob_cfg_pkg::*;

    // head points at the next free entry, tail at the oldest
    rob_id_t            head_q;
    rob_id_t            tail_q;
    rob_id_t            head_p1;
    rob_id_t            tail_p1;
    logic [ROB_WIDTH:0] count_q;
    logic [1:0]         disp_num;
    logic [1:0]         commit_num;

    assign disp_num   = {1'b0, dispatch_valid_i[0]} + {1'b0, dispatch_valid_i[1]};
    assign commit_num = {1'b0, commit_req_i[0]} + {1'b0, commit_req_i[1]};
    assign head_p1    = head_q + 1'b1;
    assign tail_p1    = tail_q + 1'b1;

    //////////////////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + rob_id_t'(disp_num);
            tail_q  <= tail_q + rob_id_t'(commit_num);
            count_q <= count_q + (ROB_WIDTH+1)'(disp_num) - (ROB_WIDTH+1)'(commit_num);
        end
    end

    // need room for a full pair
    assign dispatch_ready_o = (count_q <= (ROB_WIDTH+1)'(ROB_DEPTH - 2));

    assign dispatch_rob_id_o[0] = head_q;
    assign dispatch_rob_id_o[1] = head_p1;

    // instruction lanes follow the head, data comes from the top
    assign inst_addr_wr.we    = dispatch_valid_i;
    assign inst_addr_wr.waddr = {head_p1, head_q};

    //////////////////////////////////////////////////////////////
    // commit side
    //////////////////////////////////////////////////////////////

    assign tail_id_o[0] = tail_q;
    assign tail_id_o[1] = tail_p1;

    assign held_one_o = (count_q != '0);
    assign held_two_o = (count_q >= (ROB_WIDTH+1)'(2));

endmodule

`default_nettype wire

//--- rtl/rob_multiport_ram.sv
`timescale 1ns/100ps
`default_nettype none

module rob_multiport_ram #(
    parameter int DATA_WIDTH     = 1,
    parameter int R_PORTS        = 2,
    parameter bit CLEAR_ON_RESET = 1'b0
) (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    rob_write_if.dst                  wr,
    input  rob_cfg_pkg::rob_id_t      raddr_i [R_PORTS],
    output logic [DATA_WIDTH-1:0]     rdata_o [R_PORTS]
);

    import rob_cfg_pkg::*;

    logic [DATA_WIDTH-1:0] mem [ROB_DEPTH];

    //////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////

    // lane 1 is applied last, so it wins on an equal address
    always_ff @(posedge clk) begin
        if (CLEAR_ON_RESET && reset_i) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (wr.we[k]) begin
                    mem[wr.waddr[k]] <= wr.wdata[k];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////

    // combinational, a write shows up after the edge
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem[raddr_i[r]];
        end
    end

endmodule

`default_nettype wire

//--- rtl/rob_write_if.sv
`timescale 1ns/100ps
`default_nettype none

// two write lanes into one table, no handshake
interface rob_write_if #(
    parameter int WIDTH = 1
) ();

    import rob_cfg_pkg::*;

    logic [1:0]            we;
    rob_id_t [1:0]         waddr;
    logic [1:0][WIDTH-1:0] wdata;

    modport src (
        output we,
        output waddr,
        output wdata
    );

    modport dst (
        input we,
        input waddr,
        input wdata
    );

endinterface

`default_nettype wire

//--- rtl/rob_types_pkg.sv
`default_nettype none

package rob_types_pkg;

    import rob_cfg_pkg::*;

    //////////////////////////////////////////////////////////////
    // instruction table entry, written at dispatch
    //////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [PC_WIDTH-1:0]   pc;
        logic [AREG_WIDTH-1:0] areg;
        logic                  w_reg;
    } rob_inst_entry_t;

    //////////////////////////////////////////////////////////////
    // result word, two views of one 32-bit word
    //////////////////////////////////////////////////////////////

    // exception record, only meaningful with the exc flag set
    typedef struct packed {
        logic [EXC_CODE_WIDTH-1:0]            exc_code;
        logic [WORD_WIDTH-EXC_CODE_WIDTH-1:0] badva_lo;
    } rob_exc_word_t;

    typedef union packed {
        logic [WORD_WIDTH-1:0] result;
        rob_exc_word_t         exc;
    } rob_word_u;

    //////////////////////////////////////////////////////////////
    // data table entry, written by the CDB
    //////////////////////////////////////////////////////////////

    typedef struct packed {
        rob_word_u word;
        // selects the exception view of word
        logic      exc;
    } rob_data_entry_t;

endpackage

`default_nettype wire

//--- rtl/rob_cfg_pkg.sv
`default_nettype none

package rob_cfg_pkg;

    //////////////////////////////////////////////////////////////
    // buffer geometry
    //////////////////////////////////////////////////////////////

    // 16 entries, 4-bit index
    localparam int ROB_WIDTH = 4;
    localparam int ROB_DEPTH = 16;

    //////////////////////////////////////////////////////////////
    // field widths
    //////////////////////////////////////////////////////////////

    localparam int WORD_WIDTH     = 32;
    localparam int AREG_WIDTH     = 5;
    localparam int PC_WIDTH       = 32;
    localparam int EXC_CODE_WIDTH = 6;

    // entry index
    typedef logic [ROB_WIDTH-1:0] rob_id_t;

endpackage

`default_nettype wire
